//--- logic/spi_bridge_cfg.svh
`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

`default_nettype none

// Byte width on SPI and on the bus
`define BRIDGE_DATA_W 8

// Bus address width
`define BRIDGE_ADDR_W 20

// Memory words, only the low address bits are decoded
`define BRIDGE_RAM_DEPTH 1024

// Cycles from strobe to acknowledge in the memory
`define BRIDGE_ACK_LAT 2

`default_nettype wire

`endif

//--- logic/spi_bridge_pkg.sv
`include "spi_bridge_cfg.svh"
`default_nettype none

package spi_bridge_pkg;

    typedef logic [`BRIDGE_DATA_W-1:0] data_t;   // One data byte
    typedef logic [`BRIDGE_ADDR_W-1:0] addr_t;   // One bus address
    typedef logic [`BRIDGE_DATA_W-1:0] cmd_t;    // Bit 7 write, bit 6 address follows, 3:0 A19:16

    // SCK domain decoder states
    // VALID is the only state with bit 2 set, so that bit can cross domains directly
    typedef enum logic [2:0] {
        SPI_WAIT_CMD = 3'b000,   // Expecting a command byte
        SPI_DATA     = 3'b001,   // Expecting the write data byte
        SPI_ADDR_HI  = 3'b010,   // Expecting A15:8
        SPI_ADDR_LO  = 3'b011,   // Expecting A7:0
        SPI_VALID    = 3'b100    // Command complete
    } spi_state_e;

    // Bus controller states
    // Bit 0 is the stall flag, bit 1 is the bus cycle
    typedef enum logic [1:0] {
        BUS_READY      = 2'b00,  // Deselected or done
        BUS_RECEIVING  = 2'b01,  // Selected, bytes still arriving
        BUS_PROCESSING = 2'b11   // Bus cycle in flight
    } bus_state_e;

endpackage

`default_nettype wire

//--- logic/sync2_edge_detect.sv
`timescale 1ns/100ps
`default_nettype none

module sync2_edge_detect (
    input  logic clk_i,    // Destination clock
    input  logic rst_i,    // Asynchronous, active high
    input  logic data_i,   // Level from another clock domain
    output logic data_o,   // Synchronized level
    output logic rise_o,   // One cycle on a rising edge
    output logic fall_o    // One cycle on a falling edge
);

    logic [1:0] sync_q;   // Two synchronizing stages
    logic       dly_q;    // Previous synchronized value

    // Flops idle high so an idle chip select gives no edge out of reset
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            sync_q <= '1;
            dly_q  <= 1'b1;
        end else begin
            sync_q <= {sync_q[0], data_i};
            dly_q  <= sync_q[1];
        end
    end

    assign data_o = sync_q[1];
    assign rise_o = sync_q[1] & ~dly_q;
    assign fall_o = ~sync_q[1] & dly_q;

endmodule

`default_nettype wire

//--- logic/spi_byte_shifter.sv
`timescale 1ns/100ps
`include "spi_bridge_cfg.svh"
`default_nettype none

module spi_byte_shifter (
    input  logic                  mcu_cs_n_i,   // Chip select, active low, also clears the shifter
    input  logic                  mcu_sck_i,    // Serial clock, idles low
    input  logic                  mcu_sd_i,     // MCU to bridge
    input  spi_bridge_pkg::data_t tx_byte_i,    // Byte to send, loaded at each byte start
    output logic                  mcu_sd_o,     // Bridge to MCU
    output spi_bridge_pkg::data_t rx_byte_o,    // Received byte, valid with byte_done_o
    output logic                  byte_done_o   // Last bit of a byte is on the line
);

    localparam int CNT_W = $clog2(`BRIDGE_DATA_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`BRIDGE_DATA_W - 1);

    logic [CNT_W-1:0]          bit_cnt;    // Bits received in the current byte
    logic [`BRIDGE_DATA_W-2:0] rx_shift;   // All bits of the byte but the last
    spi_bridge_pkg::data_t     tx_shift;   // Outgoing bits, MSB on the line
    logic                      tx_armed;   // Set once the first falling edge has passed

    // Bit counter in the SCK domain
    always_ff @(posedge mcu_sck_i or posedge mcu_cs_n_i) begin
        if (mcu_cs_n_i) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;   // Wraps at the byte boundary
        end
    end

    // Sample on the rising edge, MSB first
    always_ff @(posedge mcu_sck_i) begin
        rx_shift <= {rx_shift[`BRIDGE_DATA_W-3:0], mcu_sd_i};
    end

    // The final bit comes straight from the pin so the decoder sees
    // the whole byte on the same rising edge that completes it
    assign rx_byte_o   = {rx_shift, mcu_sd_i};
    assign byte_done_o = (bit_cnt == LAST_BIT);

    always_ff @(negedge mcu_sck_i or posedge mcu_cs_n_i) begin
        if (mcu_cs_n_i) begin
            tx_armed <= 1'b0;
        end else begin
            tx_armed <= 1'b1;
        end
    end

    // Drive on the falling edge
    always_ff @(negedge mcu_sck_i) begin
        if (bit_cnt == '0) begin
            tx_shift <= tx_byte_i;                                  // Start of a following byte
        end else if (!tx_armed) begin
            tx_shift <= {tx_byte_i[`BRIDGE_DATA_W-2:0], 1'b0};      // MSB already went out
        end else begin
            tx_shift <= {tx_shift[`BRIDGE_DATA_W-2:0], 1'b0};
        end
    end

    // Mode 0 needs the first MSB before any SCK edge
    assign mcu_sd_o = tx_armed ? tx_shift[`BRIDGE_DATA_W-1] : tx_byte_i[`BRIDGE_DATA_W-1];

endmodule

`default_nettype wire

//--- logic/bus_ram.sv
`timescale 1ns/100ps
`include "spi_bridge_cfg.svh"
`default_nettype none

module bus_ram (
    input  logic                  clk_i,
    input  logic                  rst_i,         // Asynchronous, active high
    input  spi_bridge_pkg::addr_t bus_addr_i,    // Low bits decoded only
    input  spi_bridge_pkg::data_t bus_wdata_i,
    input  logic                  bus_we_i,      // 1 = write
    input  logic                  bus_cyc_i,
    input  logic                  bus_stb_i,
    output spi_bridge_pkg::data_t bus_rdata_o,   // Valid with bus_ack_o
    output logic                  bus_ack_o      // Fixed latency after the strobe
);

    localparam int IDX_W = $clog2(`BRIDGE_RAM_DEPTH);
    localparam int LAT   = `BRIDGE_ACK_LAT;

    spi_bridge_pkg::data_t mem [`BRIDGE_RAM_DEPTH] = '{default: '0};   // Starts cleared

    logic [IDX_W-1:0] idx;        // Word index, upper address bits alias
    logic             req;        // Strobe inside a cycle
    logic [LAT-1:0]   ack_pipe;   // One stage per cycle of latency

    assign idx = bus_addr_i[IDX_W-1:0];
    assign req = bus_cyc_i & bus_stb_i;

    // Write on the strobe, read registered on the same strobe
    always_ff @(posedge clk_i) begin
        if (req) begin
            if (bus_we_i) begin
                mem[idx] <= bus_wdata_i;
            end
            bus_rdata_o <= mem[idx];   // Held until the next strobe
        end
    end

    // Ack delay line
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe <= LAT'({ack_pipe, req});
        end
    end

    assign bus_ack_o = ack_pipe[LAT-1];

endmodule

`default_nettype wire

//--- logic/spi_bus_controller.sv
`timescale 1ns/100ps
`include "spi_bridge_cfg.svh"
`default_nettype none

module spi_bus_controller (
    input  logic                  spi_cs_ni,     // System clock
    input  logic                  spi_sck_i,     // System reset, asynchronous, active high

    input  logic                  mcu_cs_n_i,    // SPI chip select, active low
    input  logic                  mcu_sck_i,     // SPI clock
    input  logic                  mcu_sd_i,      // MCU to bridge
    output logic                  mcu_sd_o,      // Bridge to MCU
    output logic                  stall_o,       // MCU waits while high

    output spi_bridge_pkg::addr_t bus_addr_o,    // Held while bus_cyc_o is high
    output spi_bridge_pkg::data_t bus_wdata_o,   // Write data
    output logic                  bus_we_o,      // 1 = write
    output logic                  bus_cyc_o,     // From strobe until ack
    output logic                  bus_stb_o,     // One cycle per command
    input  spi_bridge_pkg::data_t bus_rdata_i,   // Valid with bus_ack_i
    input  logic                  bus_ack_i      // Ends the cycle
);

    spi_bridge_pkg::data_t      rx_byte;      // Byte from the shifter
    spi_bridge_pkg::data_t      tx_byte;      // Last read data, sent in the next transaction
    spi_bridge_pkg::cmd_t       cmd;          // rx_byte viewed as a command
    logic                       byte_done;
    spi_bridge_pkg::spi_state_e spi_state;
    logic                       cmd_valid;    // SCK domain, decoder holds a full command
    logic                       selected;     // Chip select fell
    logic                       deselected;   // Chip select rose
    logic                       cmd_pulse;    // Command became valid
    spi_bridge_pkg::bus_state_e bus_state;

    spi_byte_shifter i_shifter (
        .mcu_cs_n_i  (mcu_cs_n_i),
        .mcu_sck_i   (mcu_sck_i),
        .mcu_sd_i    (mcu_sd_i),
        .tx_byte_i   (tx_byte),
        .mcu_sd_o    (mcu_sd_o),
        .rx_byte_o   (rx_byte),
        .byte_done_o (byte_done)
    );

    assign cmd = rx_byte;

    // Decoder state, cleared whenever the MCU deselects
    always_ff @(posedge mcu_sck_i or posedge mcu_cs_n_i) begin
        if (mcu_cs_n_i) begin
            spi_state <= spi_bridge_pkg::SPI_WAIT_CMD;
        end else if (byte_done) begin
            case (spi_state)
                spi_bridge_pkg::SPI_WAIT_CMD: begin
                    if (cmd[6]) begin
                        spi_state <= spi_bridge_pkg::SPI_ADDR_HI;
                    end else if (cmd[7]) begin
                        spi_state <= spi_bridge_pkg::SPI_DATA;
                    end else begin
                        spi_state <= spi_bridge_pkg::SPI_VALID;   // Read, next address
                    end
                end
                spi_bridge_pkg::SPI_ADDR_HI: spi_state <= spi_bridge_pkg::SPI_ADDR_LO;
                spi_bridge_pkg::SPI_ADDR_LO: begin
                    // Direction was latched with the command byte
                    spi_state <= bus_we_o ? spi_bridge_pkg::SPI_DATA
                                          : spi_bridge_pkg::SPI_VALID;
                end
                spi_bridge_pkg::SPI_DATA:  spi_state <= spi_bridge_pkg::SPI_VALID;
                spi_bridge_pkg::SPI_VALID: spi_state <= spi_bridge_pkg::SPI_VALID;  // Extra bytes ignored
                default:                   spi_state <= spi_bridge_pkg::SPI_WAIT_CMD;
            endcase
        end
    end

    // Address survives deselect so auto-increment carries over
    always_ff @(posedge mcu_sck_i) begin
        if (byte_done) begin
            case (spi_state)
                spi_bridge_pkg::SPI_WAIT_CMD: begin
                    bus_we_o <= cmd[7];
                    if (cmd[6]) begin
                        bus_addr_o[`BRIDGE_ADDR_W-1:16] <= cmd[`BRIDGE_ADDR_W-17:0];  // A19:16
                    end else begin
                        bus_addr_o <= bus_addr_o + 1'b1;
                    end
                end
                spi_bridge_pkg::SPI_ADDR_HI: bus_addr_o[15:8] <= rx_byte;
                spi_bridge_pkg::SPI_ADDR_LO: bus_addr_o[7:0]  <= rx_byte;
                spi_bridge_pkg::SPI_DATA:    bus_wdata_o      <= rx_byte;
                default: begin
                end
            endcase
        end
    end

    assign cmd_valid = spi_state[2];   // Flop output, safe to synchronize

    // Chip select into the system clock domain
    sync2_edge_detect i_sync_cs (
        .clk_i  (spi_cs_ni),
        .rst_i  (spi_sck_i),
        .data_i (mcu_cs_n_i),
        .data_o (),
        .rise_o (deselected),
        .fall_o (selected)
    );

    // Command valid into the system clock domain
    sync2_edge_detect i_sync_valid (
        .clk_i  (spi_cs_ni),
        .rst_i  (spi_sck_i),
        .data_i (cmd_valid),
        .data_o (),
        .rise_o (cmd_pulse),
        .fall_o ()
    );

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bus_state <= spi_bridge_pkg::BUS_READY;
            bus_stb_o <= 1'b0;
        end else if (deselected) begin
            bus_state <= spi_bridge_pkg::BUS_READY;   // Any state
            bus_stb_o <= 1'b0;
        end else begin
            bus_stb_o <= 1'b0;   // Strobe never lasts past one cycle
            case (bus_state)
                spi_bridge_pkg::BUS_READY: begin
                    if (selected) begin
                        bus_state <= spi_bridge_pkg::BUS_RECEIVING;   // Stall rises here
                    end
                end
                spi_bridge_pkg::BUS_RECEIVING: begin
                    if (cmd_pulse) begin
                        bus_stb_o <= 1'b1;
                        bus_state <= spi_bridge_pkg::BUS_PROCESSING;
                    end
                end
                spi_bridge_pkg::BUS_PROCESSING: begin
                    if (bus_ack_i) begin
                        bus_state <= spi_bridge_pkg::BUS_READY;   // Stall and cycle drop next
                    end
                end
                default: bus_state <= spi_bridge_pkg::BUS_READY;
            endcase
        end
    end

    // Only reads update the byte returned to the MCU
    always_ff @(posedge spi_cs_ni) begin
        if (bus_cyc_o && bus_ack_i && !bus_we_o) begin
            tx_byte <= bus_rdata_i;
        end
    end

    assign stall_o   = bus_state[0];
    assign bus_cyc_o = bus_state[1];

endmodule

`default_nettype wire

//--- logic/spi_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module spi_bridge_top (
    input  logic spi_cs_ni,    // System clock
    input  logic spi_sck_i,    // System reset, asynchronous, active high
    input  logic mcu_cs_n_i,   // SPI chip select, active low
    input  logic mcu_sck_i,    // SPI clock
    input  logic mcu_sd_i,     // MCU to bridge
    output logic mcu_sd_o,     // Bridge to MCU
    output logic stall_o       // MCU waits while high
);

    // Bus between the controller and the memory
    spi_bridge_pkg::addr_t bus_addr;
    spi_bridge_pkg::data_t bus_wdata;
    spi_bridge_pkg::data_t bus_rdata;
    logic                  bus_we;
    logic                  bus_cyc;
    logic                  bus_stb;
    logic                  bus_ack;

    spi_bus_controller i_ctrl (
        .spi_cs_ni   (spi_cs_ni),
        .spi_sck_i   (spi_sck_i),
        .mcu_cs_n_i  (mcu_cs_n_i),
        .mcu_sck_i   (mcu_sck_i),
        .mcu_sd_i    (mcu_sd_i),
        .mcu_sd_o    (mcu_sd_o),
        .stall_o     (stall_o),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_we_o    (bus_we),
        .bus_cyc_o   (bus_cyc),
        .bus_stb_o   (bus_stb),
        .bus_rdata_i (bus_rdata),
        .bus_ack_i   (bus_ack)
    );

    // Stands in for the rest of the system
    bus_ram i_ram (
        .clk_i       (spi_cs_ni),
        .rst_i       (spi_sck_i),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_we_i    (bus_we),
        .bus_cyc_i   (bus_cyc),
        .bus_stb_i   (bus_stb),
        .bus_rdata_o (bus_rdata),
        .bus_ack_o   (bus_ack)
    );

endmodule

`default_nettype wire

//--- testbench/spi_bridge_properties.sv
`timescale 1ns/100ps
`default_nettype none

module spi_bridge_properties (
    input logic clk_i,       // System clock
    input logic rst_i,       // System reset, active high
    input logic bus_cyc_i,
    input logic bus_stb_i,
    input logic bus_ack_i,
    input logic stall_i      // Stall flag toward the MCU
);

    // Single cycle strobe per command
    a_stb_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_stb_i |=> !bus_stb_i)
        else $error("bus_stb lasted more than one cycle");

    a_stb_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_stb_i |-> bus_cyc_i)
        else $error("bus_stb without bus_cyc");

    // Memory may only answer an open cycle
    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_ack_i |-> bus_cyc_i)
        else $error("bus_ack outside a bus cycle");

    // Stall drops in the cycle after the acknowledge
    a_stall_after_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_ack_i |=> !stall_i)
        else $error("stall still high after bus_ack");

endmodule

bind spi_bus_controller spi_bridge_properties i_props (
    .clk_i     (spi_cs_ni),
    .rst_i     (spi_sck_i),
    .bus_cyc_i (bus_cyc_o),
    .bus_stb_i (bus_stb_o),
    .bus_ack_i (bus_ack_i),
    .stall_i   (stall_o)
);

`default_nettype wire

//--- testbench/spi_bridge_tb.sv
`timescale 1ns/100ps
`include "spi_bridge_cfg.svh"
`default_nettype none

module spi_bridge_tb;

    localparam int SCK_HALF    = 4;     // System cycles per SCK half period
    localparam int STALL_LIMIT = 200;   // Cycles allowed for each stall edge
    localparam int IDX_W       = $clog2(`BRIDGE_RAM_DEPTH);
    localparam int N_RANDOM    = 40;

    logic spi_cs_ni;    // System clock
    logic spi_sck_i;    // System reset
    logic mcu_cs_n_i;
    logic mcu_sck_i;
    logic mcu_sd_i;
    logic mcu_sd_o;
    logic stall_o;

    spi_bridge_pkg::data_t model [`BRIDGE_RAM_DEPTH];   // Mirror of the memory
    spi_bridge_pkg::addr_t last_addr;                   // Address of the previous command
    spi_bridge_pkg::addr_t exp_bus_addr;                // Address the current command strobes
    spi_bridge_pkg::data_t pending_rdata;               // Byte due in the next transaction
    logic                  pending_valid;
    int                    exp_q [$];                   // Expected first byte, -1 if none
    spi_bridge_pkg::data_t got_q [$];                   // First byte seen per transaction
    int                    stall_high_cycles = 0;       // Clock cycles with stall_o high
    int                    checks_done = 0;

    spi_bridge_top i_dut (
        .spi_cs_ni  (spi_cs_ni),
        .spi_sck_i  (spi_sck_i),
        .mcu_cs_n_i (mcu_cs_n_i),
        .mcu_sck_i  (mcu_sck_i),
        .mcu_sd_i   (mcu_sd_i),
        .mcu_sd_o   (mcu_sd_o),
        .stall_o    (stall_o)
    );

    always #10 spi_cs_ni = ~spi_cs_ni;   // 20 ns period

    // Lets a transaction prove that stall rose while it was selected
    always @(posedge spi_cs_ni) begin
        if (stall_o === 1'b1) begin
            stall_high_cycles <= stall_high_cycles + 1;
        end
    end

    task automatic end_on_failure();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            end_on_failure();
        end
    endtask

    // Returns 2 ns after a rising edge, n cycles later
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge spi_cs_ni);
        #2;
    endtask

    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        while (stall_o !== 1'b0) begin
            if (cycles == STALL_LIMIT) begin
                $display("Timeout at %0t: stall_o did not fall within %0d cycles",
                         $time, STALL_LIMIT);
                end_on_failure();
            end
            wait_cycles(1);
            cycles++;
        end
    endtask

    task automatic wait_stall_seen(input int start_count);
        int cycles;
        cycles = 0;
        while (stall_high_cycles == start_count) begin
            if (cycles == STALL_LIMIT) begin
                $display("Timeout at %0t: stall_o never rose during the transaction", $time);
                end_on_failure();
            end
            wait_cycles(1);
            cycles++;
        end
    endtask

    // Mode 0, MSB first, SCK at one eighth of the system clock
    task automatic spi_xfer_byte(input spi_bridge_pkg::data_t tx,
                                 output spi_bridge_pkg::data_t rx);
        for (int i = `BRIDGE_DATA_W - 1; i >= 0; i--) begin
            mcu_sd_i = tx[i];
            wait_cycles(SCK_HALF);
            rx[i] = mcu_sd_o;   // Sampled just before the rising edge
            mcu_sck_i = 1'b1;
            wait_cycles(SCK_HALF);
            mcu_sck_i = 1'b0;
        end
    endtask

    // Frame bytes sit left aligned in frame, len of them are sent
    task automatic spi_transaction(input logic [31:0] frame, input int len);
        int                    start_count;
        spi_bridge_pkg::data_t rx;
        wait_stall_low();
        start_count = stall_high_cycles;
        mcu_cs_n_i = 1'b0;
        wait_cycles(SCK_HALF);
        for (int k = 0; k < len; k++) begin
            spi_xfer_byte(frame[31 - 8 * k -: 8], rx);
            if (k == 0) begin
                got_q.push_back(rx);   // Carries the last read data
            end
        end
        wait_stall_seen(start_count);
        wait_stall_low();   // Stall must drop before deselect
        mcu_cs_n_i = 1'b1;
        wait_cycles(SCK_HALF);
    endtask

    // Bus address that a command should reach
    function automatic spi_bridge_pkg::addr_t expected_addr(
        input spi_bridge_pkg::cmd_t  cmd,
        input spi_bridge_pkg::data_t addr_hi,
        input spi_bridge_pkg::data_t addr_lo,
        input spi_bridge_pkg::addr_t prev
    );
        if (cmd[6]) begin
            return {cmd[3:0], addr_hi, addr_lo};
        end
        return prev + 1'b1;   // Wraps at the top of the 20 bit space
    endfunction

    // Memory decodes only the low address bits
    function automatic spi_bridge_pkg::data_t expected_rdata(input spi_bridge_pkg::addr_t addr);
        return model[addr[IDX_W-1:0]];
    endfunction

    task automatic run_command(input logic write, input logic addressed,
                               input spi_bridge_pkg::addr_t addr,
                               input spi_bridge_pkg::data_t wdata);
        spi_bridge_pkg::cmd_t  cmd;
        spi_bridge_pkg::addr_t target;
        logic [31:0]           frame;
        int                    len;
        cmd    = {write, addressed, 2'b00, addr[19:16]};
        target = expected_addr(cmd, addr[15:8], addr[7:0], last_addr);
        frame  = '0;
        frame[31:24] = cmd;
        len    = 1;
        if (addressed) begin
            frame[23:16] = addr[15:8];
            frame[15:8]  = addr[7:0];
            len = 3;
        end
        if (write) begin
            frame[31 - 8 * len -: 8] = wdata;   // Data byte closes the frame
            len++;
        end
        exp_q.push_back(pending_valid ? int'(pending_rdata) : -1);
        exp_bus_addr = target;
        spi_transaction(frame, len);
        last_addr = target;
        if (write) begin
            model[target[IDX_W-1:0]] = wdata;
        end else begin
            pending_rdata = expected_rdata(target);
            pending_valid = 1'b1;
        end
    endtask

    // Full 20 bit address at each strobe, A19:16 included
    always @(negedge spi_cs_ni) begin
        if (i_dut.bus_stb === 1'b1) begin
            check_equal("bus_addr", 32'(i_dut.bus_addr), 32'(exp_bus_addr));
        end
    end

    // Pairs each returned first byte with its expected value
    always @(posedge spi_cs_ni) begin
        int                    exp_byte;
        spi_bridge_pkg::data_t got_byte;
        while (got_q.size() > 0) begin
            got_byte = got_q.pop_front();
            exp_byte = exp_q.pop_front();
            if (exp_byte >= 0) begin
                check_equal("mcu_sd_o", 32'(got_byte), 32'(exp_byte));
                checks_done <= checks_done + 1;
            end
        end
    end

    initial begin
        logic                  rnd_write;
        logic                  rnd_addressed;
        spi_bridge_pkg::addr_t rnd_addr;
        spi_bridge_pkg::data_t rnd_data;
        void'($urandom(34));
        spi_cs_ni     = 1'b0;
        spi_sck_i     = 1'b1;
        mcu_cs_n_i    = 1'b1;
        mcu_sck_i     = 1'b0;
        mcu_sd_i      = 1'b0;
        pending_valid = 1'b0;
        pending_rdata = '0;
        last_addr     = '0;
        for (int i = 0; i < `BRIDGE_RAM_DEPTH; i++) begin
            model[i] = '0;
        end
        wait_cycles(2);
        spi_sck_i = 1'b0;
        wait_cycles(2);
        check_equal("stall_o", 32'(stall_o), 32'h0);

        // Write then read back at an explicit address
        run_command(1'b1, 1'b1, 20'h00123, 8'hA5);
        run_command(1'b0, 1'b1, 20'h00123, 8'h00);

        // Auto increment on writes and on reads
        run_command(1'b1, 1'b1, 20'h00200, 8'h11);
        run_command(1'b1, 1'b0, 20'h00000, 8'h22);
        run_command(1'b1, 1'b0, 20'h00000, 8'h33);
        run_command(1'b1, 1'b0, 20'h00000, 8'h44);
        run_command(1'b0, 1'b1, 20'h00200, 8'h00);
        run_command(1'b0, 1'b0, 20'h00000, 8'h00);
        run_command(1'b0, 1'b0, 20'h00000, 8'h00);
        run_command(1'b0, 1'b0, 20'h00000, 8'h00);

        // A19:16 from the command byte, alias through the low 10 bits
        run_command(1'b1, 1'b1, 20'hF0155, 8'h5A);
        run_command(1'b0, 1'b1, 20'h00155, 8'h00);
        run_command(1'b0, 1'b1, 20'h3C555, 8'h00);

        for (int n = 0; n < N_RANDOM; n++) begin
            rnd_write     = ($urandom() & 1) == 1;
            rnd_addressed = ($urandom() & 3) != 0;
            rnd_addr      = spi_bridge_pkg::addr_t'($urandom()) & 20'hF001F;   // Small window
            rnd_data      = spi_bridge_pkg::data_t'($urandom());
            run_command(rnd_write, rnd_addressed, rnd_addr, rnd_data);
        end

        run_command(1'b0, 1'b1, 20'h00000, 8'h00);   // Brings out the last read data
        wait_cycles(4);

        if (exp_q.size() != 0 || got_q.size() != 0) begin
            $display("Unmatched transactions remain after the last command");
            end_on_failure();
        end else begin
            $display("%0d returned bytes compared", checks_done);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/spi_bridge_pkg.sv
logic/sync2_edge_detect.sv
logic/spi_byte_shifter.sv
logic/bus_ram.sv
logic/spi_bus_controller.sv
logic/spi_bridge_top.sv
testbench/spi_bridge_properties.sv
testbench/spi_bridge_tb.sv

//--- Makefile
# Verilator simulation of the SPI to memory bridge

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run spi_bridge_tb, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module spi_bridge_tb -Mdir obj_dir -f sim.f
	@./obj_dir/Vspi_bridge_tb > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation log is clean"

clean:
	rm -rf obj_dir $(LOG)
